//--- Bender.yml
package:
  name: bicubic_upsample

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bicubic_pkg.sv
      - verilog/bicubic_dot4.sv
      - verilog/bicubic_sequencer.sv
      - verilog/bicubic_vertical_bank.sv
      - verilog/bicubic_horizontal_stage.sv
      - verilog/bicubic_upsample_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verification/bicubic_upsample_tb.sv

//--- bicubic_upsample.f
+incdir+verilog
verilog/bicubic_pkg.sv
verilog/bicubic_dot4.sv
verilog/bicubic_sequencer.sv
verilog/bicubic_vertical_bank.sv
verilog/bicubic_horizontal_stage.sv
verilog/bicubic_upsample_top.sv
verification/bicubic_upsample_tb.sv

//--- verification/bicubic_upsample_tb.sv
`include "bicubic_config.svh"

module bicubic_upsample_tb import bicubic_pkg::*; ();

    localparam int RANDOM_WINDOWS  = 8;
    localparam int TOTAL_WINDOWS   = 3 + 3 + 2 * RANDOM_WINDOWS;
    localparam int WATCHDOG_CYCLES = TOTAL_WINDOWS * 16 * 4 + 200;
    localparam int MAX_WINDOWS     = 16;

    // Bicubic weights scaled by 128, one row per sub pixel phase
    localparam int TAP_WEIGHT [4][4] = '{
        '{ 0, 128,   0,  0},
        '{-9, 111,  29, -3},
        '{-8,  72,  72, -8},
        '{-3,  29, 111, -9}
    };

    logic   clk;
    logic   arst_n;
    logic   in_valid;
    logic   in_ready;
    pixel_t pix [16];
    logic   out_valid;
    logic   out_ready;
    pixel_t out_pix;
    logic   out_last;

    pixel_t      windows [MAX_WINDOWS][16];
    pixel_t      expected_q [$];
    logic [31:0] lcg_state;
    int          value_errors;
    int          other_errors;

    bicubic_upsample_top dut0 (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .pix_0     (pix[0]),
        .pix_1     (pix[1]),
        .pix_2     (pix[2]),
        .pix_3     (pix[3]),
        .pix_4     (pix[4]),
        .pix_5     (pix[5]),
        .pix_6     (pix[6]),
        .pix_7     (pix[7]),
        .pix_8     (pix[8]),
        .pix_9     (pix[9]),
        .pix_10    (pix[10]),
        .pix_11    (pix[11]),
        .pix_12    (pix[12]),
        .pix_13    (pix[13]),
        .pix_14    (pix[14]),
        .pix_15    (pix[15]),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_pix   (out_pix),
        .out_last  (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES + 8) @(posedge clk);
        $display("Simulation timed out before all outputs arrived");
        $display("Verification failed");
        $finish;
    end

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_pixel(input string name, input pixel_t expected, input pixel_t actual);
        if (actual !== expected) begin
            $display("error %s expected 0x%02h actual 0x%02h at %0t", name, expected, actual,
                     $time);
            value_errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("error %s expected 0x%01h actual 0x%01h at %0t", name, expected, actual,
                     $time);
            value_errors++;
        end
    endtask

    // Separable filter, floor after each pass, clamp only at the end
    task automatic model_window(input int w);
        int v [4];
        int acc;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                for (int j = 0; j < 4; j++) begin
                    acc = 0;
                    for (int i = 0; i < 4; i++) begin
                        acc += TAP_WEIGHT[r][i] * int'(windows[w][4 * i + j]);
                    end
                    v[j] = acc >>> `BICUBIC_FRAC_BITS;
                end
                acc = 0;
                for (int j = 0; j < 4; j++) begin
                    acc += TAP_WEIGHT[c][j] * v[j];
                end
                acc = acc >>> `BICUBIC_FRAC_BITS;
                if (acc < 0) acc = 0;
                if (acc > 255) acc = 255;
                expected_q.push_back(pixel_t'(acc));
            end
        end
    endtask

    // Feeds windows 0 to n_win-1 and checks every output pixel in order
    task automatic stream_windows(input int n_win, input bit random_ready);
        int          sent;
        int          got;
        logic [31:0] rnd;
        sent = 0;
        got  = 0;
        expected_q.delete();
        for (int w = 0; w < n_win; w++) begin
            model_window(w);
        end
        while (got < n_win * 16) begin
            @(negedge clk);
            if (random_ready) begin
                rnd       = next_random();
                out_ready = rnd[20];
            end else begin
                out_ready = 1'b1;
            end
            if (sent < n_win) begin
                in_valid = 1'b1;
                for (int k = 0; k < 16; k++) pix[k] = windows[sent][k];
            end else begin
                in_valid = 1'b0;
            end
            #1;                                 // Let in_ready settle after out_ready
            if (!random_ready && got > 0 && !out_valid) begin
                $display("Output stream paused between back to back windows");
                other_errors++;
            end
            if (out_valid && out_ready) begin
                check_pixel("out_pix", expected_q.pop_front(), out_pix);
                check_bit("out_last", (got % 16) == 15, out_last);
                got++;
            end
            if (in_valid && in_ready) sent++;
        end
        @(negedge clk);
        in_valid  = 1'b0;
        out_ready = 1'b1;
        #1;
        if (out_valid) begin
            $display("An extra output pixel appeared after the last expected one");
            other_errors++;
        end
        check_bit("in_ready", 1'b1, in_ready);
    endtask

    task automatic test_reset();
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("in_ready", 1'b1, in_ready);
    endtask

    task automatic test_flat();
        pixel_t level [3];
        level = '{8'h00, 8'h4d, 8'hff};
        for (int w = 0; w < 3; w++) begin
            for (int k = 0; k < 16; k++) windows[w][k] = level[w];
        end
        stream_windows(3, 1'b0);
    endtask

    task automatic test_bright_pixel();
        for (int w = 0; w < 3; w++) begin
            for (int k = 0; k < 16; k++) windows[w][k] = 8'h00;
        end
        windows[0][5] = 8'hc8;                  // Phase 0 lands on this pixel
        windows[1][1] = 8'hff;                  // Negative lobe drives some outputs below 0
        // Two pixel squares put 255 on the whole centre cell so its middle overshoots
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                windows[2][4 * i + j] = ((i == 1 || i == 2) == (j == 1 || j == 2)) ?
                                        8'hff : 8'h00;
            end
        end
        stream_windows(3, 1'b0);
    endtask

    task automatic test_random_stream();
        logic [31:0] rnd;
        for (int w = 0; w < RANDOM_WINDOWS; w++) begin
            for (int k = 0; k < 16; k++) begin
                rnd           = next_random();
                windows[w][k] = rnd[23:16];
            end
        end
        stream_windows(RANDOM_WINDOWS, 1'b0);
    endtask

    // Reuses the windows of the streaming test
    task automatic test_random_backpressure();
        stream_windows(RANDOM_WINDOWS, 1'b1);
    endtask

    initial begin
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        out_ready    = 1'b0;
        lcg_state    = 32'd92312;
        value_errors = 0;
        other_errors = 0;
        for (int k = 0; k < 16; k++) pix[k] = 8'h00;
        repeat (8) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        #1;
        test_reset();
        test_flat();
        test_bright_pixel();
        test_random_stream();
        test_random_backpressure();
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- verilog/bicubic_config.svh
`ifndef BICUBIC_CONFIG_SVH
`define BICUBIC_CONFIG_SVH

// Coefficients are scaled by 1 << BICUBIC_FRAC_BITS
`define BICUBIC_FRAC_BITS 7

// Taps per filter pass and window width
`define BICUBIC_TAPS 4

`endif

//--- verilog/bicubic_dot4.sv
`include "bicubic_config.svh"

module bicubic_dot4 import bicubic_pkg::*; #(
    parameter type sample_t = pixel_t
) (
    input  sample_t           s0,
    input  sample_t           s1,
    input  sample_t           s2,
    input  sample_t           s3,
    input  coef_t             c0,
    input  coef_t             c1,
    input  coef_t             c2,
    input  coef_t             c3,
    output logic signed [11:0] sum
);

    // One spare bit for unsigned samples and two for the four term sum
    localparam int ACC_W = $bits(sample_t) + $bits(coef_t) + 3;

    logic signed [ACC_W-1:0] ext [4];
    logic signed [ACC_W-1:0] prod [4];
    logic signed [ACC_W-1:0] acc;
    logic signed [ACC_W-1:0] scaled;

    assign ext[0] = s0;                         // Extension follows the sample signedness
    assign ext[1] = s1;
    assign ext[2] = s2;
    assign ext[3] = s3;

    assign prod[0] = ext[0] * c0;
    assign prod[1] = ext[1] * c1;
    assign prod[2] = ext[2] * c2;
    assign prod[3] = ext[3] * c3;

    assign acc    = prod[0] + prod[1] + prod[2] + prod[3];
    assign scaled = acc >>> `BICUBIC_FRAC_BITS; // Floor division by 128
    assign sum    = scaled[11:0];

endmodule

//--- verilog/bicubic_horizontal_stage.sv
`include "bicubic_config.svh"

module bicubic_horizontal_stage import bicubic_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   mid_valid,
    output logic   mid_ready,
    input  mid_t   mid_0,
    input  mid_t   mid_1,
    input  mid_t   mid_2,
    input  mid_t   mid_3,
    input  phase_t mid_col_phase,
    input  logic   mid_last,
    output logic   out_valid,
    input  logic   out_ready,
    output pixel_t out_pix,
    output logic   out_last
);

    coef_t              col_coef [`BICUBIC_TAPS];
    logic signed [11:0] row_sum;
    pixel_t             clamped;
    logic               out_valid_q;
    pixel_t             out_pix_q;
    logic               out_last_q;
    logic               mid_fire;

    assign mid_ready = ~out_valid_q | out_ready;
    assign mid_fire  = mid_valid & mid_ready;

    always_comb begin
        for (int i = 0; i < `BICUBIC_TAPS; i++) begin
            col_coef[i] = bicubic_coef(mid_col_phase, i);
        end
    end

    bicubic_dot4 #(.sample_t(mid_t)) u_row_filter (
        .s0  (mid_0),
        .s1  (mid_1),
        .s2  (mid_2),
        .s3  (mid_3),
        .c0  (col_coef[0]),
        .c1  (col_coef[1]),
        .c2  (col_coef[2]),
        .c3  (col_coef[3]),
        .sum (row_sum)
    );

    // Negative lobes can undershoot 0 and overshoot 255 near sharp edges
    always_comb begin
        if (row_sum < 0) begin
            clamped = 8'd0;
        end else if (row_sum > 12'sd255) begin
            clamped = 8'd255;
        end else begin
            clamped = row_sum[7:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid_q <= 1'b0;
        end else if (mid_ready) begin
            out_valid_q <= mid_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mid_fire) begin
            out_pix_q  <= clamped;
            out_last_q <= mid_last;
        end
    end

    assign out_valid = out_valid_q;
    assign out_pix   = out_pix_q;
    assign out_last  = out_last_q;

    a_out_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid && !out_ready |=> $stable(out_pix) && $stable(out_last));

endmodule

//--- verilog/bicubic_pkg.sv
`include "bicubic_config.svh"

package bicubic_pkg;

    typedef logic [7:0] pixel_t;                // Source or output pixel
    typedef logic signed [9:0] mid_t;           // Vertical pass result
    typedef logic signed [8:0] coef_t;          // Nine bits so the unity tap 128 fits
    typedef logic [1:0] phase_t;                // Sub pixel phase in quarters

    localparam int PHASES = 4;

    // Phase p interpolates at p/4 between tap 1 and tap 2
    localparam coef_t COEF_TABLE [PHASES][`BICUBIC_TAPS] = '{
        '{  9'sd0, 9'sd128,   9'sd0,   9'sd0},
        '{ -9'sd9, 9'sd111,  9'sd29,  -9'sd3},
        '{ -9'sd8,  9'sd72,  9'sd72,  -9'sd8},
        '{ -9'sd3,  9'sd29, 9'sd111,  -9'sd9}
    };

    function automatic coef_t bicubic_coef(input phase_t phase, input int unsigned tap);
        return COEF_TABLE[phase][tap];          // Each row sums to 128
    endfunction

endpackage

//--- verilog/bicubic_sequencer.sv
module bicubic_sequencer import bicubic_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  pixel_t pix_0,
    input  pixel_t pix_1,
    input  pixel_t pix_2,
    input  pixel_t pix_3,
    input  pixel_t pix_4,
    input  pixel_t pix_5,
    input  pixel_t pix_6,
    input  pixel_t pix_7,
    input  pixel_t pix_8,
    input  pixel_t pix_9,
    input  pixel_t pix_10,
    input  pixel_t pix_11,
    input  pixel_t pix_12,
    input  pixel_t pix_13,
    input  pixel_t pix_14,
    input  pixel_t pix_15,
    output logic   issue_valid,
    input  logic   issue_ready,
    output phase_t row_phase,
    output phase_t col_phase,
    output logic   last,
    output pixel_t win_0,
    output pixel_t win_1,
    output pixel_t win_2,
    output pixel_t win_3,
    output pixel_t win_4,
    output pixel_t win_5,
    output pixel_t win_6,
    output pixel_t win_7,
    output pixel_t win_8,
    output pixel_t win_9,
    output pixel_t win_10,
    output pixel_t win_11,
    output pixel_t win_12,
    output pixel_t win_13,
    output pixel_t win_14,
    output pixel_t win_15
);

    pixel_t [15:0] win_q;
    logic          full_q;
    logic [3:0]    step_q;
    logic          in_fire;
    logic          issue_fire;

    assign issue_valid = full_q;
    assign row_phase   = step_q[3:2];
    assign col_phase   = step_q[1:0];
    assign last        = (step_q == 4'd15);
    assign issue_fire  = issue_valid & issue_ready;

    // A new window may enter while the last phase of the old one leaves
    assign in_ready = ~full_q | (issue_fire & last);
    assign in_fire  = in_valid & in_ready;

    // Step wraps to 0 after phase 15 so a freshly loaded window starts there
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            full_q <= 1'b0;
            step_q <= 4'd0;
        end else begin
            if (issue_fire) begin
                step_q <= step_q + 4'd1;
            end
            if (in_fire) begin
                full_q <= 1'b1;
            end else if (issue_fire && last) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            win_q <= {pix_15, pix_14, pix_13, pix_12, pix_11, pix_10, pix_9, pix_8,
                      pix_7, pix_6, pix_5, pix_4, pix_3, pix_2, pix_1, pix_0};
        end
    end

    assign win_0  = win_q[0];
    assign win_1  = win_q[1];
    assign win_2  = win_q[2];
    assign win_3  = win_q[3];
    assign win_4  = win_q[4];
    assign win_5  = win_q[5];
    assign win_6  = win_q[6];
    assign win_7  = win_q[7];
    assign win_8  = win_q[8];
    assign win_9  = win_q[9];
    assign win_10 = win_q[10];
    assign win_11 = win_q[11];
    assign win_12 = win_q[12];
    assign win_13 = win_q[13];
    assign win_14 = win_q[14];
    assign win_15 = win_q[15];

    // A window loads only into an idle sequencer parked at step 0 or as phase 15 leaves
    a_window_held: assert property (@(posedge clk) disable iff (!arst_n)
        in_fire |-> (!full_q && step_q == 4'd0) || (issue_fire && last));

endmodule

//--- verilog/bicubic_upsample_top.sv
module bicubic_upsample_top import bicubic_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   in_valid,
    output logic   in_ready,
    input  pixel_t pix_0,
    input  pixel_t pix_1,
    input  pixel_t pix_2,
    input  pixel_t pix_3,
    input  pixel_t pix_4,
    input  pixel_t pix_5,
    input  pixel_t pix_6,
    input  pixel_t pix_7,
    input  pixel_t pix_8,
    input  pixel_t pix_9,
    input  pixel_t pix_10,
    input  pixel_t pix_11,
    input  pixel_t pix_12,
    input  pixel_t pix_13,
    input  pixel_t pix_14,
    input  pixel_t pix_15,
    output logic   out_valid,
    input  logic   out_ready,
    output pixel_t out_pix,
    output logic   out_last
);

    logic   issue_valid;
    logic   issue_ready;
    phase_t row_phase;
    phase_t col_phase;
    logic   last;
    pixel_t win_0, win_1, win_2, win_3, win_4, win_5, win_6, win_7;
    pixel_t win_8, win_9, win_10, win_11, win_12, win_13, win_14, win_15;
    logic   mid_valid;
    logic   mid_ready;
    mid_t   mid_0, mid_1, mid_2, mid_3;
    phase_t mid_col_phase;
    logic   mid_last;

    bicubic_sequencer u_sequencer (
        .clk, .arst_n, .in_valid, .in_ready,
        .pix_0, .pix_1, .pix_2, .pix_3, .pix_4, .pix_5, .pix_6, .pix_7,
        .pix_8, .pix_9, .pix_10, .pix_11, .pix_12, .pix_13, .pix_14, .pix_15,
        .issue_valid, .issue_ready, .row_phase, .col_phase, .last,
        .win_0, .win_1, .win_2, .win_3, .win_4, .win_5, .win_6, .win_7,
        .win_8, .win_9, .win_10, .win_11, .win_12, .win_13, .win_14, .win_15
    );

    // Column filters run on the row phase of the issued step
    bicubic_vertical_bank u_vertical_bank (
        .clk, .arst_n, .issue_valid, .issue_ready, .row_phase, .col_phase, .last,
        .win_0, .win_1, .win_2, .win_3, .win_4, .win_5, .win_6, .win_7,
        .win_8, .win_9, .win_10, .win_11, .win_12, .win_13, .win_14, .win_15,
        .mid_valid, .mid_ready, .mid_0, .mid_1, .mid_2, .mid_3,
        .mid_col_phase, .mid_last
    );

    bicubic_horizontal_stage u_horizontal_stage (
        .clk, .arst_n, .mid_valid, .mid_ready,
        .mid_0, .mid_1, .mid_2, .mid_3, .mid_col_phase, .mid_last,
        .out_valid, .out_ready, .out_pix, .out_last
    );

endmodule

//--- verilog/bicubic_vertical_bank.sv
`include "bicubic_config.svh"

module bicubic_vertical_bank import bicubic_pkg::*; (
    input  logic   clk,
    input  logic   arst_n,
    input  logic   issue_valid,
    output logic   issue_ready,
    input  phase_t row_phase,
    input  phase_t col_phase,
    input  logic   last,
    input  pixel_t win_0,
    input  pixel_t win_1,
    input  pixel_t win_2,
    input  pixel_t win_3,
    input  pixel_t win_4,
    input  pixel_t win_5,
    input  pixel_t win_6,
    input  pixel_t win_7,
    input  pixel_t win_8,
    input  pixel_t win_9,
    input  pixel_t win_10,
    input  pixel_t win_11,
    input  pixel_t win_12,
    input  pixel_t win_13,
    input  pixel_t win_14,
    input  pixel_t win_15,
    output logic   mid_valid,
    input  logic   mid_ready,
    output mid_t   mid_0,
    output mid_t   mid_1,
    output mid_t   mid_2,
    output mid_t   mid_3,
    output phase_t mid_col_phase,
    output logic   mid_last
);

    // Reachable span of a vertical sum for 8-bit pixels and the coefficient table
    localparam int MID_MIN = -32;
    localparam int MID_MAX = 286;

    pixel_t [15:0]     win;
    coef_t             row_coef [`BICUBIC_TAPS];
    logic signed [11:0] col_sum [`BICUBIC_TAPS];
    mid_t              mid_q [`BICUBIC_TAPS];
    logic              mid_valid_q;
    phase_t            mid_col_phase_q;
    logic              mid_last_q;
    logic              issue_fire;

    assign win = {win_15, win_14, win_13, win_12, win_11, win_10, win_9, win_8,
                  win_7, win_6, win_5, win_4, win_3, win_2, win_1, win_0};

    assign issue_ready = ~mid_valid_q | mid_ready;
    assign issue_fire  = issue_valid & issue_ready;

    always_comb begin
        for (int i = 0; i < `BICUBIC_TAPS; i++) begin
            row_coef[i] = bicubic_coef(row_phase, i);
        end
    end

    for (genvar j = 0; j < `BICUBIC_TAPS; j++) begin : g_col
        bicubic_dot4 #(.sample_t(pixel_t)) u_col_filter (
            .s0  (win[j]),
            .s1  (win[`BICUBIC_TAPS + j]),
            .s2  (win[2 * `BICUBIC_TAPS + j]),
            .s3  (win[3 * `BICUBIC_TAPS + j]),
            .c0  (row_coef[0]),
            .c1  (row_coef[1]),
            .c2  (row_coef[2]),
            .c3  (row_coef[3]),
            .sum (col_sum[j])
        );

        a_mid_range: assert property (@(posedge clk) disable iff (!arst_n)
            mid_valid_q |-> (mid_q[j] >= MID_MIN) && (mid_q[j] <= MID_MAX));
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mid_valid_q <= 1'b0;
        end else if (issue_ready) begin
            mid_valid_q <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_fire) begin
            for (int j = 0; j < `BICUBIC_TAPS; j++) begin
                mid_q[j] <= col_sum[j][$bits(mid_t)-1:0]; // Range fits without saturation
            end
            mid_col_phase_q <= col_phase;
            mid_last_q      <= last;
        end
    end

    assign mid_valid     = mid_valid_q;
    assign mid_0         = mid_q[0];
    assign mid_1         = mid_q[1];
    assign mid_2         = mid_q[2];
    assign mid_3         = mid_q[3];
    assign mid_col_phase = mid_col_phase_q;
    assign mid_last      = mid_last_q;

endmodule
